// File: common/mem_stage_cfg.svh
/* memory stage configuration
   register width, address map and privilege codes */

`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

`define XLEN            32                // integer register width

// ------------------------------
// address map
// ------------------------------
`define PHYS_LO         32'h0000_0000     // physical memory, served by L1 D$
`define PHYS_HI         32'h7FFF_FFFF
`define EXT_IO_LO       32'h8000_0000     // external I/O bus
`define EXT_IO_HI       32'h8FFF_FFFF
`define INT_IO_LO       32'hFFFF_0000     // internal timer block
`define INT_IO_HI       32'hFFFF_00FF

// timer registers, high halves live at +4
`define MTIME_ADDR      32'hFFFF_0000
`define MTIMECMP_ADDR   32'hFFFF_0008
`define MSIP_ADDR       32'hFFFF_0010

// ------------------------------
// privilege
// ------------------------------
`define M_MODE          2'd3              // machine mode
`define MSIP_BIT        3                 // sw_irq position in msip read value

`endif

// File: common/mem_stage_pkg.sv
/* memory stage types
   vector typedefs and the structs carried on every bus of the stage */

`include "mem_stage_cfg.svh"

package mem_stage_pkg;

   typedef logic [`XLEN-1:0]   word_t;       // data word
   typedef logic [`XLEN-1:0]   addr_t;       // load/store address
   typedef logic [2*`XLEN-1:0] dword_t;      // mtime / mtimecmp
   typedef logic [4:0]         reg_addr_t;   // gpr number
   typedef logic [2:0]         ls_size_t;    // bytes: 1, 2 or 4
   typedef logic [1:0]         priv_t;       // privilege mode

   // ------------------------------
   // pipeline buses
   // ------------------------------
   typedef struct packed {
      logic      is_ld;
      logic      is_st;
      addr_t     ls_addr;
      word_t     st_data;
      ls_size_t  size;
      logic      zero_ext;                  // LBU / LHU
      logic      inv_flag;
      priv_t     priv;                      // mode the instruction runs in
      logic      sw_irq;                    // current msip state
      logic      rd_wr;
      reg_addr_t rd_addr;
      word_t     rd_data;                   // execute result
      word_t     instr_tag;
   } e2m_t;

   typedef struct packed {
      word_t     instr_tag;
      addr_t     ls_addr;                   // needed for fault reporting in wb
      logic      rd_wr;
      reg_addr_t rd_addr;
      word_t     rd_data;
      logic      mio_fault;
   } m2w_t;

   // ------------------------------
   // memory and I/O buses
   // ------------------------------
   typedef struct packed {
      logic      rd;
      logic      wr;
      addr_t     addr;
      word_t     wr_data;
      ls_size_t  size;
      logic      zero_ext;
      logic      inv_flag;
   } dc_req_t;

   typedef struct packed {
      logic      ack;
      word_t     ack_data;
      logic      ack_fault;
   } dc_rsp_t;

   typedef struct packed {
      logic      rd;
      logic      wr;
      addr_t     addr;
      word_t     wr_data;
   } eio_req_t;

   typedef struct packed {
      logic      ack;
      word_t     ack_data;
      logic      ack_fault;
   } eio_rsp_t;

   typedef struct packed {
      logic      rd;
      logic      wr;
      addr_t     addr;
      word_t     wr_data;
      priv_t     priv;
   } mio_req_t;

   typedef struct packed {
      logic      ack;
      word_t     data;
      logic      fault;
   } mio_rsp_t;

   typedef struct packed {
      logic      msip;
      logic      mtime_lo;
      logic      mtime_hi;
      logic      mtimecmp_lo;
      logic      mtimecmp_hi;
      word_t     data;                      // store data for all strobes
   } mmr_wr_t;

   typedef struct packed {
      logic      valid;
      logic      rd_wr;
      reg_addr_t rd_addr;
      word_t     rd_data;
   } fwd_gpr_t;

endpackage

// File: compile.f
+incdir+common
common/mem_stage_pkg.sv
mem_stage/mio_router.sv
mem_stage/int_io_access.sv
logic/mem_pipe_reg.sv
mem_stage/mem_stage.sv
tests/tb_clock.sv
tests/mem_stage_tb.sv

// File: logic/mem_pipe_reg.sv
/* memory to writeback pipeline register
   execute-side ready, result assembly, one-entry register and gpr forwarding */

`timescale 1ns/1ns

module mem_pipe_reg
(
   input  logic                    clk_in,
   input  logic                    reset,
   input  logic                    cpu_halt,
   input  logic                    pipe_flush,

   input  logic                    e2m_valid,
   input  mem_stage_pkg::e2m_t     e2m_data,
   output logic                    e2m_ready,

   input  mem_stage_pkg::mio_rsp_t mio_rsp,      // answer of the selected target

   output logic                    m2w_valid,
   output mem_stage_pkg::m2w_t     m2w_data,
   input  logic                    m2w_ready,

   output mem_stage_pkg::fwd_gpr_t fwd_gpr
);

   import mem_stage_pkg::*;

   logic is_ls;
   logic xfer_in;                                // execute -> this stage
   logic xfer_out;                               // this stage -> writeback
   logic pipe_full;
   m2w_t result;                                 // entry to be captured

   assign is_ls = e2m_data.is_ld | e2m_data.is_st;

   // ------------------------------
   // handshake
   // ------------------------------
   // a load/store stalls here until its target acknowledges
   assign e2m_ready = !reset & !cpu_halt & (!is_ls | mio_rsp.ack) &
                      (!pipe_full | xfer_out);

   assign xfer_in  = e2m_valid & e2m_ready;
   assign xfer_out = m2w_valid & m2w_ready;

   // ------------------------------
   // result assembly
   // ------------------------------
   always_comb
   begin
      result.instr_tag = e2m_data.instr_tag;
      result.ls_addr   = e2m_data.ls_addr;
      result.rd_wr     = e2m_data.rd_wr;
      result.rd_addr   = e2m_data.rd_addr;
      result.rd_data   = e2m_data.rd_data;       // execute result by default
      result.mio_fault = 1'b0;
      if (e2m_data.is_ld)
         result.rd_data = mio_rsp.data;          // load data replaces it
      if (is_ls)
         result.mio_fault = mio_rsp.fault;
   end

   // gpr bypass of the instruction sitting at the stage input
   assign fwd_gpr.valid   = e2m_valid & !reset;
   assign fwd_gpr.rd_wr   = e2m_data.rd_wr;
   assign fwd_gpr.rd_addr = e2m_data.rd_addr;
   assign fwd_gpr.rd_data = result.rd_data;

   // ------------------------------
   // one-entry register
   // ------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset | pipe_flush)
         pipe_full <= 1'b0;
      else if (xfer_in)
         pipe_full <= 1'b1;                      // refill even when draining
      else if (xfer_out)
         pipe_full <= 1'b0;
   end

   always_ff @(posedge clk_in)
   begin
      if (xfer_in)
         m2w_data <= result;                     // held steady under back-pressure
   end

   assign m2w_valid = pipe_full;

endmodule

// File: mem_stage/int_io_access.sv
/* internal timer register access
   machine mode only, gives mtime/mtimecmp/msip write strobes and read data */

`timescale 1ns/1ns

`include "mem_stage_cfg.svh"

module int_io_access
(
   input  logic                    int_io_sel,   // request decoded to this block
   input  mem_stage_pkg::mio_req_t mio_req,
   input  logic                    sw_irq,       // current msip bit
   input  mem_stage_pkg::dword_t   mtime,
   input  mem_stage_pkg::dword_t   mtimecmp,
   output mem_stage_pkg::mmr_wr_t  mmr_wr,
   output mem_stage_pkg::mio_rsp_t int_io_rsp
);

   import mem_stage_pkg::*;

   logic m_mode;
   logic hit_mtime_lo;
   logic hit_mtime_hi;
   logic hit_mtimecmp_lo;
   logic hit_mtimecmp_hi;
   logic hit_msip;
   logic hit_any;
   logic wr_ok;                                  // legal store into the block
   logic rd_ok;                                  // legal load from the block

   // ------------------------------
   // address match
   // ------------------------------
   assign m_mode          = (mio_req.priv == `M_MODE);

   assign hit_mtime_lo    = (mio_req.addr == `MTIME_ADDR);
   assign hit_mtime_hi    = (mio_req.addr == (`MTIME_ADDR + 32'd4));
   assign hit_mtimecmp_lo = (mio_req.addr == `MTIMECMP_ADDR);
   assign hit_mtimecmp_hi = (mio_req.addr == (`MTIMECMP_ADDR + 32'd4));
   assign hit_msip        = (mio_req.addr == `MSIP_ADDR);

   assign hit_any = hit_mtime_lo | hit_mtime_hi | hit_mtimecmp_lo |
                    hit_mtimecmp_hi | hit_msip;

   assign wr_ok = int_io_sel & m_mode & mio_req.wr;
   assign rd_ok = int_io_sel & m_mode & mio_req.rd;

   // ------------------------------
   // write strobes
   // ------------------------------
   assign mmr_wr.mtime_lo    = wr_ok & hit_mtime_lo;
   assign mmr_wr.mtime_hi    = wr_ok & hit_mtime_hi;
   assign mmr_wr.mtimecmp_lo = wr_ok & hit_mtimecmp_lo;
   assign mmr_wr.mtimecmp_hi = wr_ok & hit_mtimecmp_hi;
   assign mmr_wr.msip        = wr_ok & hit_msip;
   assign mmr_wr.data        = mio_req.wr_data;   // qualified by the strobes

   // ------------------------------
   // response
   // ------------------------------
   always_comb
   begin
      int_io_rsp.ack   = int_io_sel;             // always answers in the same cycle
      int_io_rsp.fault = int_io_sel & !(m_mode & hit_any);
      int_io_rsp.data  = '0;

      if (rd_ok)
      begin
         if (hit_mtime_lo)
            int_io_rsp.data = mtime[`XLEN-1:0];
         else if (hit_mtime_hi)
            int_io_rsp.data = mtime[2*`XLEN-1:`XLEN];
         else if (hit_mtimecmp_lo)
            int_io_rsp.data = mtimecmp[`XLEN-1:0];
         else if (hit_mtimecmp_hi)
            int_io_rsp.data = mtimecmp[2*`XLEN-1:`XLEN];
         else if (hit_msip)
            int_io_rsp.data[`MSIP_BIT] = sw_irq; // other msip bits read zero
      end
   end

endmodule

// File: mem_stage/mem_stage.sv
/* memory stage top
   routes loads/stores to D$, timer regs or external I/O, registers result for wb */

`timescale 1ns/1ns

module mem_stage
(
   input  logic                    clk_in,
   input  logic                    reset,
   input  logic                    cpu_halt,     // stop accepting from execute
   input  logic                    pipe_flush,   // drop the entry toward wb

   // execute side
   input  logic                    e2m_valid,
   input  mem_stage_pkg::e2m_t     e2m_data,
   output logic                    e2m_ready,

   // writeback side
   output logic                    m2w_valid,
   output mem_stage_pkg::m2w_t     m2w_data,
   input  logic                    m2w_ready,

   // targets
   output mem_stage_pkg::dc_req_t  dc_req,
   input  mem_stage_pkg::dc_rsp_t  dc_rsp,
   output mem_stage_pkg::eio_req_t eio_req,
   input  mem_stage_pkg::eio_rsp_t eio_rsp,

   // timer block
   input  mem_stage_pkg::dword_t   mtime,
   input  mem_stage_pkg::dword_t   mtimecmp,
   output mem_stage_pkg::mmr_wr_t  mmr_wr,

   output mem_stage_pkg::fwd_gpr_t fwd_gpr      // gpr bypass
);

   import mem_stage_pkg::*;

   logic      int_io_sel;                        // request decoded to timer block
   mio_req_t  mio_req;
   mio_rsp_t  int_io_rsp;                        // timer block answer
   mio_rsp_t  mio_rsp;                           // answer of the selected target

   mio_router router_i
   (
      .e2m_valid  (e2m_valid),
      .e2m_data   (e2m_data),
      .cpu_halt   (cpu_halt),
      .reset      (reset),
      .dc_req     (dc_req),
      .dc_rsp     (dc_rsp),
      .eio_req    (eio_req),
      .eio_rsp    (eio_rsp),
      .int_io_sel (int_io_sel),
      .mio_req    (mio_req),
      .int_io_rsp (int_io_rsp),
      .mio_rsp    (mio_rsp)
   );

   int_io_access int_io_i
   (
      .int_io_sel (int_io_sel),
      .mio_req    (mio_req),
      .sw_irq     (e2m_data.sw_irq),
      .mtime      (mtime),
      .mtimecmp   (mtimecmp),
      .mmr_wr     (mmr_wr),
      .int_io_rsp (int_io_rsp)
   );

   mem_pipe_reg pipe_i
   (
      .clk_in     (clk_in),
      .reset      (reset),
      .cpu_halt   (cpu_halt),
      .pipe_flush (pipe_flush),
      .e2m_valid  (e2m_valid),
      .e2m_data   (e2m_data),
      .e2m_ready  (e2m_ready),
      .mio_rsp    (mio_rsp),
      .m2w_valid  (m2w_valid),
      .m2w_data   (m2w_data),
      .m2w_ready  (m2w_ready),
      .fwd_gpr    (fwd_gpr)
   );

endmodule

// File: mem_stage/mio_router.sv
/* load/store router
   decodes the address region, drives D$ or external I/O, muxes the acknowledge */

`timescale 1ns/1ns

`include "mem_stage_cfg.svh"

module mio_router
(
   input  logic                    e2m_valid,
   input  mem_stage_pkg::e2m_t     e2m_data,
   input  logic                    cpu_halt,
   input  logic                    reset,

   output mem_stage_pkg::dc_req_t  dc_req,
   input  mem_stage_pkg::dc_rsp_t  dc_rsp,

   output mem_stage_pkg::eio_req_t eio_req,
   input  mem_stage_pkg::eio_rsp_t eio_rsp,

   output logic                    int_io_sel,
   output mem_stage_pkg::mio_req_t mio_req,
   input  mem_stage_pkg::mio_rsp_t int_io_rsp,

   output mem_stage_pkg::mio_rsp_t mio_rsp
);

   import mem_stage_pkg::*;

   addr_t ls_addr;
   logic  is_ld;
   logic  is_st;
   logic  req_live;                              // load or store being presented now
   logic  in_phys;
   logic  in_ext;
   logic  in_int;
   logic  sel_phys;
   logic  sel_ext;

   assign ls_addr  = e2m_data.ls_addr;
   assign is_ld    = e2m_data.is_ld;
   assign is_st    = e2m_data.is_st;

   assign req_live = e2m_valid & !reset & !cpu_halt & (is_ld | is_st);

   // ------------------------------
   // region decode
   // ------------------------------
   // ranges do not overlap, so at most one select is high
   assign in_phys    = (ls_addr >= `PHYS_LO)   & (ls_addr <= `PHYS_HI);
   assign in_ext     = (ls_addr >= `EXT_IO_LO) & (ls_addr <= `EXT_IO_HI);
   assign in_int     = (ls_addr >= `INT_IO_LO) & (ls_addr <= `INT_IO_HI);

   assign sel_phys   = req_live & in_phys;
   assign sel_ext    = req_live & in_ext;
   assign int_io_sel = req_live & in_int;

   // internal request, consumed by the timer block
   assign mio_req.rd      = req_live & is_ld;
   assign mio_req.wr      = req_live & is_st;
   assign mio_req.addr    = ls_addr;
   assign mio_req.wr_data = e2m_data.st_data;
   assign mio_req.priv    = e2m_data.priv;

   // ------------------------------
   // target requests
   // ------------------------------
   // D$ strobes stay up until dc_rsp.ack lets the instruction move on
   assign dc_req.rd       = sel_phys & is_ld;
   assign dc_req.wr       = sel_phys & is_st;
   assign dc_req.addr     = ls_addr;
   assign dc_req.wr_data  = e2m_data.st_data;
   assign dc_req.size     = e2m_data.size;     // 1, 2 or 4 bytes
   assign dc_req.zero_ext = e2m_data.zero_ext;
   assign dc_req.inv_flag = e2m_data.inv_flag;

   always_comb
   begin
      eio_req = '0;                             // bus is quiet unless selected
      if (sel_ext)
      begin
         eio_req.rd      = is_ld;
         eio_req.wr      = is_st;
         eio_req.addr    = ls_addr;
         eio_req.wr_data = e2m_data.st_data;
      end
   end

   // ------------------------------
   // acknowledge mux
   // ------------------------------
   always_comb
   begin
      mio_rsp = '0;
      if (sel_phys)
      begin
         mio_rsp.ack   = dc_rsp.ack;           // D$ decides the latency
         mio_rsp.data  = dc_rsp.ack_data;
         mio_rsp.fault = dc_rsp.ack_fault;
      end
      else if (int_io_sel)
      begin
         mio_rsp = int_io_rsp;                  // same-cycle answer
      end
      else if (sel_ext)
      begin
         mio_rsp.ack   = eio_rsp.ack;
         mio_rsp.fault = eio_rsp.ack_fault;
         if (is_ld & !eio_rsp.ack_fault)
            mio_rsp.data = eio_rsp.ack_data;   // faulted load returns zero
      end
      else
      begin
         // unmapped address, end the access at once with a fault
         mio_rsp.ack   = req_live;
         mio_rsp.fault = req_live;
      end
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the memory stage testbench with Verilator, run it, and grade the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f compile.f --top-module mem_stage_tb \
   -Mdir obj_dir -o mem_stage_sim > build.log 2>&1 &&
./obj_dir/mem_stage_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

// File: tests/mem_stage_tb.sv
/* memory stage testbench
   target models, scoreboard and checks over all access regions */

`timescale 1ns/1ns

`include "mem_stage_cfg.svh"

module mem_stage_tb;

   import mem_stage_pkg::*;

   logic clk, reset, cpu_halt, pipe_flush, e2m_valid, e2m_ready, m2w_valid, m2w_ready;
   e2m_t e2m_data;
   m2w_t m2w_data;
   dc_req_t dc_req;
   dc_rsp_t dc_rsp;
   eio_req_t eio_req;
   eio_rsp_t eio_rsp;
   dword_t mtime, mtimecmp;
   mmr_wr_t mmr_wr;
   fwd_gpr_t fwd_gpr;

   logic [15:0] lfsr;
   logic [1:0] dc_cnt, eio_cnt;                  // remaining model delay
   m2w_t exp_q[$];
   m2w_t exp_r, prev_data;
   eio_req_t exp_eio;
   logic xfer, live, prev_xfer, prev_stall, prev_flush, prev_reset;
   int errors, cycles, n_pass, n_fail, err_mark;

   tb_clock clk_i (.clk(clk));

   mem_stage dut_i
   (
      .clk_in(clk), .reset(reset), .cpu_halt(cpu_halt), .pipe_flush(pipe_flush),
      .e2m_valid(e2m_valid), .e2m_data(e2m_data), .e2m_ready(e2m_ready),
      .m2w_valid(m2w_valid), .m2w_data(m2w_data), .m2w_ready(m2w_ready),
      .dc_req(dc_req), .dc_rsp(dc_rsp), .eio_req(eio_req), .eio_rsp(eio_rsp),
      .mtime(mtime), .mtimecmp(mtimecmp), .mmr_wr(mmr_wr), .fwd_gpr(fwd_gpr)
   );

   // ------------------------------
   // helpers
   // ------------------------------
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // taps 16,14,13,11
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic check_val(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
      assert (got === exp)
      else
      begin
         $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   function automatic logic in_phys(input addr_t a);
      return (a >= `PHYS_LO) && (a <= `PHYS_HI);
   endfunction
   function automatic logic in_ext(input addr_t a);
      return (a >= `EXT_IO_LO) && (a <= `EXT_IO_HI);
   endfunction
   function automatic logic in_int(input addr_t a);
      return (a >= `INT_IO_LO) && (a <= `INT_IO_HI);
   endfunction

   function automatic word_t cache_data(input addr_t a);
      return {a[15:0], ~a[15:0]};
   endfunction
   function automatic word_t ext_data(input addr_t a);
      return a ^ 32'hA5A5_0000;
   endfunction

   // expected writeback entry of an instruction, by region
   function automatic m2w_t predict(input e2m_t d, input logic eio_fault);
      m2w_t r;
      word_t rdv;
      logic ok;
      r = '0;
      r.instr_tag = d.instr_tag;
      r.ls_addr = d.ls_addr;
      r.rd_wr = d.rd_wr;
      r.rd_addr = d.rd_addr;
      r.rd_data = d.rd_data;                       // stores keep the execute result
      if (!(d.is_ld | d.is_st))
         return r;
      if (d.is_ld)
         r.rd_data = '0;
      if (in_phys(d.ls_addr))
      begin
         r.mio_fault = (d.ls_addr[27:24] == 4'hF);
         if (d.is_ld)
            r.rd_data = cache_data(d.ls_addr);
      end
      else if (in_ext(d.ls_addr))
      begin
         r.mio_fault = eio_fault;
         if (d.is_ld && !eio_fault)
            r.rd_data = ext_data(d.ls_addr);
      end
      else if (in_int(d.ls_addr))
      begin
         ok = (d.priv == `M_MODE);
         rdv = '0;
         case (d.ls_addr)
            `MTIME_ADDR:             rdv = mtime[31:0];
            `MTIME_ADDR + 32'd4:     rdv = mtime[63:32];
            `MTIMECMP_ADDR:          rdv = mtimecmp[31:0];
            `MTIMECMP_ADDR + 32'd4:  rdv = mtimecmp[63:32];
            `MSIP_ADDR:              rdv[`MSIP_BIT] = d.sw_irq;
            default:                 ok = 1'b0;
         endcase
         if (ok && d.is_ld)
            r.rd_data = rdv;
         r.mio_fault = !ok;
      end
      else
         r.mio_fault = 1'b1;                       // unmapped
      return r;
   endfunction

   function automatic e2m_t make_ls(input logic ld, input addr_t a, input word_t v,
                                    input priv_t p, input logic irq, input word_t tag);
      e2m_t d;
      d = '0;
      d.is_ld = ld;
      d.is_st = !ld;
      d.ls_addr = a;
      d.st_data = v;
      d.size = 3'd4;
      d.zero_ext = a[0];
      d.inv_flag = a[1];
      d.priv = p;
      d.sw_irq = irq;
      d.rd_wr = ld;
      d.rd_addr = a[6:2];
      d.rd_data = 32'hDEAD_BEEF;                  // replaced for loads
      d.instr_tag = tag;
      return d;
   endfunction

   function automatic e2m_t make_alu(input reg_addr_t rd, input word_t v, input word_t tag);
      e2m_t d;
      d = '0;
      d.rd_wr = 1'b1;
      d.rd_addr = rd;
      d.rd_data = v;
      d.priv = `M_MODE;
      d.instr_tag = tag;
      return d;
   endfunction

   // present one instruction and hold it until it is taken
   task automatic issue(input e2m_t d);
      @(posedge clk);
      e2m_valid <= 1'b1;
      e2m_data <= d;
      @(posedge clk);
      while (!e2m_ready)
         @(posedge clk);
      e2m_valid <= 1'b0;
   endtask

   task automatic finish_test(input string name);
      @(posedge clk);
      while (exp_q.size() != 0)
         @(posedge clk);
      @(posedge clk);                              // checks one cycle behind the last entry
      @(negedge clk);
      if (errors == err_mark)
      begin
         n_pass++;
         $display("test %s: ok", name);
      end
      else
      begin
         n_fail++;
         $display("test %s: failed with %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
      @(posedge clk);
   endtask

   // ------------------------------
   // target models
   // ------------------------------
   always @(posedge clk)
   begin
      logic [31:0] v;
      if (reset)
      begin
         dc_rsp <= '0;
         draw_bits(2, v);
         dc_cnt <= v[1:0];
      end
      else if (dc_rsp.ack)
      begin
         if ((e2m_valid && e2m_ready) || !(dc_req.rd | dc_req.wr))
         begin
            dc_rsp <= '0;
            draw_bits(2, v);
            dc_cnt <= v[1:0];
         end
      end
      else if (dc_req.rd | dc_req.wr)
      begin
         if (dc_cnt == 2'd0)
         begin
            dc_rsp.ack <= 1'b1;
            dc_rsp.ack_data <= cache_data(dc_req.addr);
            dc_rsp.ack_fault <= (dc_req.addr[27:24] == 4'hF);
         end
         else
            dc_cnt <= dc_cnt - 2'd1;
      end
   end

   always @(posedge clk)
   begin
      logic [31:0] v;
      if (reset)
      begin
         eio_rsp <= '0;
         draw_bits(2, v);
         eio_cnt <= v[1:0];
      end
      else if (eio_rsp.ack)
      begin
         if ((e2m_valid && e2m_ready) || !(eio_req.rd | eio_req.wr))
         begin
            eio_rsp <= '0;
            draw_bits(2, v);
            eio_cnt <= v[1:0];
         end
      end
      else if (eio_req.rd | eio_req.wr)
      begin
         if (eio_cnt == 2'd0)
         begin
            draw_bits(2, v);                       // fault about one time in four
            eio_rsp.ack <= 1'b1;
            eio_rsp.ack_data <= ext_data(eio_req.addr);
            eio_rsp.ack_fault <= (v[1:0] == 2'd0);
         end
         else
            eio_cnt <= eio_cnt - 2'd1;
      end
   end

   // ------------------------------
   // checks
   // ------------------------------
   always @(posedge clk)
   begin
      if (reset)
      begin
         check_val("e2m_ready", e2m_ready, 0);
         check_val("fwd_gpr.valid", fwd_gpr.valid, 0);
         check_val("mmr_wr.mtime_lo", mmr_wr.mtime_lo, 0);
         if (prev_reset)
            check_val("m2w_valid", m2w_valid, 0);   // full flag settles at the first edge
         prev_reset = 1;
         prev_xfer = 0;
         prev_stall = 0;
         prev_flush = 0;
      end
      else
      begin
         xfer = e2m_valid && e2m_ready;
         live = e2m_valid && !cpu_halt && (e2m_data.is_ld | e2m_data.is_st);
         if (cpu_halt)
            check_val("e2m_ready", e2m_ready, 0);
         if (m2w_valid && !m2w_ready)
            check_val("e2m_ready", e2m_ready, 0);
         if (prev_stall)
         begin
            check_val("m2w_data", m2w_data, prev_data);
            check_val("m2w_valid", m2w_valid, 1);
         end
         if (prev_xfer && !prev_flush)
            check_val("m2w_valid", m2w_valid, 1);   // result one cycle after transfer
         if (prev_flush)
            check_val("m2w_valid", m2w_valid, 0);

         // D$ request follows the instruction and stalls it until ack
         check_val("dc_req.rd", dc_req.rd, live && in_phys(e2m_data.ls_addr) && e2m_data.is_ld);
         check_val("dc_req.wr", dc_req.wr, live && in_phys(e2m_data.ls_addr) && e2m_data.is_st);
         if (dc_req.rd | dc_req.wr)
         begin
            check_val("dc_req.addr", dc_req.addr, e2m_data.ls_addr);
            check_val("dc_req.wr_data", dc_req.wr_data, e2m_data.st_data);
            check_val("dc_req.size", dc_req.size, e2m_data.size);
            check_val("dc_req.zero_ext", dc_req.zero_ext, e2m_data.zero_ext);
            check_val("dc_req.inv_flag", dc_req.inv_flag, e2m_data.inv_flag);
            if (!dc_rsp.ack)
               check_val("e2m_ready", e2m_ready, 0);
         end

         exp_eio = '0;
         if (live && in_ext(e2m_data.ls_addr))
         begin
            exp_eio.rd = e2m_data.is_ld;
            exp_eio.wr = e2m_data.is_st;
            exp_eio.addr = e2m_data.ls_addr;
            exp_eio.wr_data = e2m_data.st_data;
         end
         check_val("eio_req", eio_req, exp_eio);

         // timer strobes, machine-mode stores only
         live = live && e2m_data.is_st && (e2m_data.priv == `M_MODE);
         check_val("mmr_wr.mtime_lo", mmr_wr.mtime_lo, live && e2m_data.ls_addr == `MTIME_ADDR);
         check_val("mmr_wr.mtime_hi", mmr_wr.mtime_hi,
                   live && e2m_data.ls_addr == `MTIME_ADDR + 32'd4);
         check_val("mmr_wr.mtimecmp_lo", mmr_wr.mtimecmp_lo,
                   live && e2m_data.ls_addr == `MTIMECMP_ADDR);
         check_val("mmr_wr.mtimecmp_hi", mmr_wr.mtimecmp_hi,
                   live && e2m_data.ls_addr == `MTIMECMP_ADDR + 32'd4);
         check_val("mmr_wr.msip", mmr_wr.msip, live && e2m_data.ls_addr == `MSIP_ADDR);
         check_val("mmr_wr.data", mmr_wr.data, e2m_data.st_data);

         check_val("fwd_gpr.valid", fwd_gpr.valid, e2m_valid);
         if (e2m_valid)
         begin
            check_val("fwd_gpr.rd_wr", fwd_gpr.rd_wr, e2m_data.rd_wr);
            check_val("fwd_gpr.rd_addr", fwd_gpr.rd_addr, e2m_data.rd_addr);
         end

         // scoreboard out side, then in side
         if (m2w_valid && m2w_ready)
         begin
            assert (exp_q.size() != 0)
            else
            begin
               $display("writeback entry at t=%0t with nothing expected", $time);
               errors++;
            end
            if (exp_q.size() != 0)
               check_val("m2w_data", m2w_data, exp_q.pop_front());
         end
         else if (pipe_flush && m2w_valid && exp_q.size() != 0)
            void'(exp_q.pop_front());              // entry dropped by flush
         if (xfer)
         begin
            exp_r = predict(e2m_data, eio_rsp.ack_fault);
            check_val("fwd_gpr.rd_data", fwd_gpr.rd_data, exp_r.rd_data);
            exp_q.push_back(exp_r);
         end

         prev_xfer = xfer;
         prev_flush = pipe_flush;
         prev_stall = m2w_valid && !m2w_ready && !pipe_flush;
         prev_data = m2w_data;
      end
   end

   // run limit, generous against the roughly 400 cycles the tests need
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= 4000)
      begin
         $display("timeout: run did not finish within 4000 cycles");
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // ------------------------------
   // stimulus
   // ------------------------------
   initial
   begin
      logic [31:0] v;
      lfsr = 16'd36;
      errors = 0;
      cycles = 0;
      n_pass = 0;
      n_fail = 0;
      err_mark = 0;
      prev_reset = 1'b0;
      reset = 1'b1;
      cpu_halt = 1'b0;
      pipe_flush = 1'b0;
      e2m_valid = 1'b1;                            // offered during reset, never taken
      e2m_data = make_alu(5'd1, 32'h0BAD_0001, 32'd98);
      m2w_ready = 1'b1;
      mtime = 64'h0123_4567_89AB_CDEF;
      mtimecmp = 64'hFEDC_BA98_7654_3210;
      repeat (3)
         @(posedge clk);
      e2m_data <= make_ls(1'b0, `MTIME_ADDR, 32'h0BAD_0002, `M_MODE, 1'b0, 32'd99);
      repeat (2)
         @(posedge clk);
      reset <= 1'b0;
      e2m_valid <= 1'b0;

      for (int i = 0; i < 8; i++)
         issue(make_ls(i[0], 32'h0000_1000 + 32'(i * 4) + (i == 5 ? 32'h0F00_0000 : 0),
                       32'h1111_0000 + 32'(i), `M_MODE, 1'b0, 32'(i)));
      finish_test("physical memory");

      for (int i = 0; i < 5; i++)
      begin
         issue(make_ls(1'b0, `MTIME_ADDR + 32'(i * 4), 32'hC0DE_0000 + 32'(i),
                       `M_MODE, 1'b0, 32'(i)));
         issue(make_ls(1'b1, `MTIME_ADDR + 32'(i * 4), '0, `M_MODE, (i == 4), 32'(i)));
      end
      finish_test("timer registers");

      issue(make_ls(1'b0, `MTIME_ADDR, 32'h5555_0000, 2'd0, 1'b0, 32'd20));
      issue(make_ls(1'b1, `MTIMECMP_ADDR, '0, 2'd1, 1'b0, 32'd21));
      issue(make_ls(1'b0, 32'hFFFF_0020, 32'h6666_0000, `M_MODE, 1'b0, 32'd22));
      issue(make_ls(1'b1, 32'hFFFF_0044, '0, `M_MODE, 1'b1, 32'd23));
      issue(make_ls(1'b1, 32'h9000_0000, '0, `M_MODE, 1'b0, 32'd24));
      issue(make_ls(1'b0, 32'hFFFF_1000, 32'h7777_0000, `M_MODE, 1'b0, 32'd25));
      finish_test("access faults");

      for (int i = 0; i < 10; i++)
         issue(make_ls(i[0], 32'h8000_0100 + 32'(i * 4), 32'h2222_0000 + 32'(i),
                       2'd0, 1'b0, 32'(30 + i)));
      finish_test("external I/O");

      m2w_ready <= 1'b0;
      issue(make_alu(5'd7, 32'hAAAA_0001, 32'd40));
      e2m_valid <= 1'b1;
      e2m_data <= make_alu(5'd8, 32'hAAAA_0002, 32'd41);
      repeat (4)
         @(posedge clk);
      m2w_ready <= 1'b1;
      while (!(e2m_valid && e2m_ready))
         @(posedge clk);
      e2m_valid <= 1'b0;
      @(posedge clk);
      cpu_halt <= 1'b1;
      e2m_valid <= 1'b1;
      e2m_data <= make_alu(5'd10, 32'hAAAA_0004, 32'd44);   // held off by halt alone
      repeat (2)
         @(posedge clk);
      e2m_data <= make_ls(1'b1, 32'h0000_2000, '0, `M_MODE, 1'b0, 32'd42);
      repeat (2)
         @(posedge clk);
      cpu_halt <= 1'b0;
      @(posedge clk);
      while (!e2m_ready)
         @(posedge clk);
      e2m_valid <= 1'b0;
      @(posedge clk);                              // load drains to writeback
      m2w_ready <= 1'b0;
      issue(make_alu(5'd9, 32'hAAAA_0003, 32'd43));
      pipe_flush <= 1'b1;
      @(posedge clk);
      pipe_flush <= 1'b0;
      m2w_ready <= 1'b1;
      finish_test("back-pressure, halt and flush");

      for (int i = 0; i < 12; i++)
      begin
         draw_bits(32, v);
         issue(make_alu(v[4:0], v, 32'(50 + i)));
      end
      finish_test("non-memory and forwarding");

      repeat (3)
         @(posedge clk);
      @(negedge clk);
      $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
      if (errors == 0 && n_fail == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: tests/tb_clock.sv
/* testbench clock source, 10 ns period */

`timescale 1ns/1ns

module tb_clock
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;      // half period
   end

endmodule
